//--- bench/dmem_asserts.sv
// Concurrent checks on the pipeline timing of the data-memory top level.
// Bound to dmem_top from the testbench.

`timescale 1ns/1ps

module dmem_asserts
  import dmem_pkg::*;
  (
  input logic clk_i,
  input logic rst_n_i,
  input logic v_i,
  input dmem_opcode_e opcode_i,
  input logic v_o,
  input logic wr_v
);

  // reset clears both pipeline valids.
  reset_clears_v_o: assert property (@(posedge clk_i)
    !rst_n_i |=> !v_o [*2])
    else $error("v_o high during or right after reset");

  v_o_two_cycles: assert property (@(posedge clk_i)
    (rst_n_i && $past(rst_n_i) && $past(rst_n_i, 2)) |-> (v_o == $past(v_i, 2)))
    else $error("v_o does not follow v_i by two cycles");

  // a write needs a store, SM or atomic accepted one cycle earlier.
  wr_needs_write_req: assert property (@(posedge clk_i)
    wr_v |-> $past(v_i && (opcode_i inside {SB, SH, SW, SD, SM,
      AMOSWAP_W, AMOADD_W, AMOXOR_W, AMOAND_W, AMOOR_W, AMOMIN_W, AMOMAX_W,
      AMOMINU_W, AMOMAXU_W, AMOSWAP_D, AMOADD_D, AMOXOR_D, AMOAND_D, AMOOR_D,
      AMOMIN_D, AMOMAX_D, AMOMINU_D, AMOMAXU_D})))
    else $error("write strobe without a store or atomic request one cycle earlier");

endmodule

//--- bench/dmem_tb.sv
// Testbench for the data-memory subsystem.
// Fills every word with SD, then sends random requests over 8 words and
// compares each response with a reference model kept in the testbench.

`timescale 1ns/1ps
`include "dmem_config.svh"

module dmem_tb
  import dmem_pkg::*;
  ();

  localparam int N_REQ = 2000;
  localparam int MAX_CYCLES = 3 * N_REQ + 200;

  logic clk, rst_n, v_i, v_o;
  dmem_opcode_e opcode_i;
  logic [`DMEM_ADDR_W-1:0] addr_i;
  logic [`DMEM_DATA_W-1:0] data_i, data_o;
  logic [`DMEM_BYTES-1:0] mask_i;

  logic [63:0] mem_model [`DMEM_WORDS];
  logic [63:0] exp_q [$];
  dmem_opcode_e op_list [32];
  integer seed = 23;
  int mismatches = 0;
  int other_errors = 0;
  int cycles = 0;

  tb_clkgen clkgen (.clk_o(clk), .rst_n_o(rst_n));

  dmem_top uut (
    .clk_i(clk), .rst_n_i(rst_n), .v_i(v_i), .opcode_i(opcode_i),
    .addr_i(addr_i), .data_i(data_i), .mask_i(mask_i), .v_o(v_o), .data_o(data_o)
  );

  bind dmem_top dmem_asserts asserts (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .v_i(v_i), .opcode_i(opcode_i), .v_o(v_o),
    .wr_v(wr_if.wr_v)
  );

  function automatic int op_bytes(input dmem_opcode_e op);
    case (op)
      LB, LBU, SB: return 1;
      LH, LHU, SH: return 2;
      LW, LWU, SW, AMOSWAP_W, AMOADD_W, AMOXOR_W, AMOAND_W, AMOOR_W,
      AMOMIN_W, AMOMAX_W, AMOMINU_W, AMOMAXU_W: return 4;
      default: return 8;
    endcase
  endfunction

  function automatic logic [63:0] sext(input logic [63:0] v, input int nb);
    case (nb)
      1: return {{56{v[7]}}, v[7:0]};
      2: return {{48{v[15]}}, v[15:0]};
      4: return {{32{v[31]}}, v[31:0]};
      default: return v;
    endcase
  endfunction

  function automatic logic [63:0] byte_lanes(input logic [7:0] m);
    logic [63:0] r;
    for (int b = 0; b < 8; b++) r[b*8 +: 8] = {8{m[b]}};
    return r;
  endfunction

  // a and b are zero-extended fields of nb bytes.
  function automatic logic [63:0] amo_calc(input dmem_opcode_e op, input logic [63:0] a,
                                           input logic [63:0] b, input int nb);
    logic s_lt;
    s_lt = $signed(sext(a, nb)) < $signed(sext(b, nb));
    case (op)
      AMOADD_W, AMOADD_D: return a + b;
      AMOXOR_W, AMOXOR_D: return a ^ b;
      AMOAND_W, AMOAND_D: return a & b;
      AMOOR_W, AMOOR_D: return a | b;
      AMOMIN_W, AMOMIN_D: return s_lt ? a : b;
      AMOMAX_W, AMOMAX_D: return s_lt ? b : a;
      AMOMINU_W, AMOMINU_D: return (a < b) ? a : b;
      AMOMAXU_W, AMOMAXU_D: return (a < b) ? b : a;
      default: return b; // swap.
    endcase
  endfunction

  // applies one request to the model and returns the expected response.
  function automatic logic [63:0] model_step(input dmem_opcode_e op, input logic [8:0] addr,
                                             input logic [63:0] data, input logic [7:0] mask);
    int nb, sh;
    logic [5:0] idx;
    logic [63:0] old, fmask, field, res, exp_v, bm;
    logic wr;
    nb = op_bytes(op);
    idx = addr[8:3];
    sh = (int'(addr[2:0]) & ~(nb - 1)) * 8;
    fmask = (nb == 8) ? '1 : ((64'd1 << (nb * 8)) - 1);
    old = mem_model[idx];
    field = (old >> sh) & fmask;
    bm = byte_lanes(mask);
    exp_v = '0;
    res = '0;
    wr = 1'b0;
    case (op)
      LB, LH, LW, LD: exp_v = sext(field, nb);
      LBU, LHU, LWU, LDU: exp_v = field;
      SB, SH, SW, SD: begin
        res = data & fmask;
        wr = 1'b1;
      end
      LM: exp_v = old & bm;
      SM: mem_model[idx] = (old & ~bm) | (data & bm);
      default: begin
        exp_v = sext(field, nb); // old value.
        res = amo_calc(op, field, data & fmask, nb) & fmask;
        wr = 1'b1;
      end
    endcase
    if (wr) mem_model[idx] = (old & ~(fmask << sh)) | (res << sh);
    return exp_v;
  endfunction

  task automatic send_req(input dmem_opcode_e op, input logic [8:0] addr,
                          input logic [63:0] data, input logic [7:0] mask);
    @(posedge clk);
    v_i <= 1'b1;
    opcode_i <= op;
    addr_i <= addr;
    data_i <= data;
    mask_i <= mask;
    exp_q.push_back(model_step(op, addr, data, mask));
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    v_i <= 1'b0;
  endtask

  always @(negedge clk) begin
    if (rst_n && v_o) begin
      if (exp_q.size() == 0) begin
        $display("response at %0t without an outstanding request", $time);
        other_errors++;
      end else if (data_o !== exp_q[0]) begin
        $display("MISMATCH at %0t: data_o %h, expected %h", $time, data_o, exp_q[0]);
        mismatches++;
        void'(exp_q.pop_front());
      end else begin
        void'(exp_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    v_i = 1'b0;
    opcode_i = LB;
    addr_i = '0;
    data_i = '0;
    mask_i = '0;
    for (int i = 0; i < 32; i++) op_list[i] = dmem_opcode_e'(i < 14 ? i : 32 + (i - 14) % 9
                                                             + ((i - 14) / 9) * 16);
    wait (rst_n === 1'b1);
    for (int w = 0; w < `DMEM_WORDS; w++) begin
      send_req(SD, {w[5:0], 3'b000}, {$random(seed), $random(seed)}, 8'hff);
    end
    for (int n = 0; n < N_REQ; n++) begin
      if (($random(seed) & 3) == 0) idle_cycle();
      send_req(op_list[$unsigned($random(seed)) % 32],
               {3'b000, 3'($random(seed)), 3'($random(seed))},
               {$random(seed), $random(seed)}, 8'($random(seed)));
    end
    idle_cycle();
    while (exp_q.size() != 0) @(negedge clk);
    repeat (4) @(posedge clk);
    $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- bench/tb_clkgen.sv
// Clock and reset source for the data-memory testbench.
// 40 ns clock; reset held low for the first 3 rising edges.

`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_n_o <= 1'b1; // released on the edge.
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the data-memory testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module dmem_tb -o Vdmem_tb

./obj_dir/Vdmem_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0

//--- sources.f
+incdir+verilog
verilog/dmem_pkg.sv
verilog/dmem_wr_if.sv
verilog/dmem_decode.sv
verilog/dmem_array.sv
verilog/dmem_data_unit.sv
verilog/dmem_top.sv
bench/tb_clkgen.sv
bench/dmem_asserts.sv
bench/dmem_tb.sv

//--- verilog/dmem_array.sv
// Tagless data array of the cache data path.
// Reads are registered in stage 1; writes come from the data unit through the
// write port and land on the following edge. A stage-1 read of the word being
// written picks up the new bytes so back-to-back operations chain.

`timescale 1ns/1ps
`include "dmem_config.svh"

module dmem_array
  (
    input logic clk_i
    , input logic [$clog2(`DMEM_WORDS)-1:0] rd_index_i
    , output logic [`DMEM_DATA_W-1:0] rd_data_o
    , dmem_wr_if.array wr
  );

  logic [`DMEM_WORDS-1:0][`DMEM_DATA_W-1:0] mem;
  logic [`DMEM_DATA_W-1:0] rd_word;
  logic [`DMEM_DATA_W-1:0] rd_merged;
  logic bypass_hit;

  assign rd_word = mem[rd_index_i];
  assign bypass_hit = wr.wr_v && (wr.wr_index == rd_index_i);

  always_comb begin
    rd_merged = rd_word;
    for (int b = 0; b < `DMEM_BYTES; b++) begin
      if (bypass_hit && wr.wr_mask[b]) begin
        rd_merged[b*8 +: 8] = wr.wr_data[b*8 +: 8]; // forward the write byte.
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < `DMEM_BYTES; b++) begin
      if (wr.wr_v && wr.wr_mask[b]) begin
        mem[wr.wr_index][b*8 +: 8] <= wr.wr_data[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    rd_data_o <= rd_merged;
  end

endmodule

//--- verilog/dmem_config.svh
// Size macros for the data-memory subsystem.
// Included by every RTL file that declares data, mask or address widths.

`ifndef DMEM_CONFIG_SVH
`define DMEM_CONFIG_SVH

`define DMEM_DATA_W 64 // bits per word.
`define DMEM_BYTES 8 // bytes per word.
`define DMEM_WORDS 64 // words in the data array.

// 6 word-index bits above 3 byte-offset bits.
`define DMEM_ADDR_W 9

`endif

//--- verilog/dmem_data_unit.sv
// Stage-2 data unit.
// Extracts and extends load fields, merges store data into byte lanes and
// runs the atomic ALU on the addressed field. Drives the array write port in
// the same cycle and registers the response.

`timescale 1ns/1ps
`include "dmem_config.svh"

module dmem_data_unit
  import dmem_pkg::*;
  (
    input logic clk_i
    , input logic rst_n_i
    , input logic v_i
    , input dmem_decode_s decode_i
    , input logic [$clog2(`DMEM_WORDS)-1:0] index_i
    , input logic [$clog2(`DMEM_BYTES)-1:0] offset_i
    , input logic [`DMEM_DATA_W-1:0] data_i
    , input logic [`DMEM_BYTES-1:0] mask_i
    , input logic [`DMEM_DATA_W-1:0] rd_data_i
    , dmem_wr_if.unit wr
    , output logic v_o
    , output logic [`DMEM_DATA_W-1:0] data_o
  );

  localparam int OFF_W = $clog2(`DMEM_BYTES);

  logic [`DMEM_BYTES-1:0] size_mask;
  logic [OFF_W-1:0] off_aligned;
  logic [OFF_W+2:0] bit_shift;
  logic [`DMEM_DATA_W-1:0] field_raw;
  logic [`DMEM_DATA_W-1:0] ld_field;
  logic [`DMEM_DATA_W-1:0] lm_word;
  logic [`DMEM_DATA_W-1:0] operand;
  logic [`DMEM_DATA_W-1:0] amo_res;
  logic [`DMEM_DATA_W-1:0] resp;
  logic lt_s;
  logic lt_u;

  // low offset bits below the access size are dropped.
  always_comb begin
    case (decode_i.data_size)
      e_dmem_size_byte: begin
        size_mask = 8'h01;
        off_aligned = offset_i;
      end
      e_dmem_size_half: begin
        size_mask = 8'h03;
        off_aligned = {offset_i[OFF_W-1:1], 1'b0};
      end
      e_dmem_size_word: begin
        size_mask = 8'h0f;
        off_aligned = {offset_i[OFF_W-1], 2'b00};
      end
      default: begin
        size_mask = 8'hff;
        off_aligned = '0;
      end
    endcase
  end

  assign bit_shift = {off_aligned, 3'b000};
  assign field_raw = rd_data_i >> bit_shift;

  always_comb begin
    case (decode_i.data_size)
      e_dmem_size_byte: ld_field = {{56{decode_i.sigext_op & field_raw[7]}}, field_raw[7:0]};
      e_dmem_size_half: ld_field = {{48{decode_i.sigext_op & field_raw[15]}}, field_raw[15:0]};
      e_dmem_size_word: ld_field = {{32{decode_i.sigext_op & field_raw[31]}}, field_raw[31:0]};
      default: ld_field = field_raw;
    endcase
  end

  always_comb begin
    for (int b = 0; b < `DMEM_BYTES; b++) begin
      lm_word[b*8 +: 8] = mask_i[b] ? rd_data_i[b*8 +: 8] : 8'h00;
    end
  end

  // word atomics compare sign-extended values, which keeps unsigned order.
  assign operand = (decode_i.data_size == e_dmem_size_word)
    ? {{32{data_i[31]}}, data_i[31:0]} : data_i;
  assign lt_s = $signed(ld_field) < $signed(operand);
  assign lt_u = ld_field < operand;

  always_comb begin
    case (decode_i.amo_subop)
      e_dmem_amo_add: amo_res = ld_field + operand;
      e_dmem_amo_xor: amo_res = ld_field ^ operand;
      e_dmem_amo_and: amo_res = ld_field & operand;
      e_dmem_amo_or: amo_res = ld_field | operand;
      e_dmem_amo_min: amo_res = lt_s ? ld_field : operand;
      e_dmem_amo_max: amo_res = lt_s ? operand : ld_field;
      e_dmem_amo_minu: amo_res = lt_u ? ld_field : operand;
      e_dmem_amo_maxu: amo_res = lt_u ? operand : ld_field;
      default: amo_res = operand; // swap.
    endcase
  end

  assign wr.wr_v = v_i & (decode_i.st_op | decode_i.atomic_op);
  assign wr.wr_index = index_i;
  assign wr.wr_data = decode_i.atomic_op ? (amo_res << bit_shift)
    : decode_i.mask_op ? data_i
    : (data_i << bit_shift);
  assign wr.wr_mask = (decode_i.mask_op & ~decode_i.atomic_op) ? mask_i
    : (size_mask << off_aligned);

  always_comb begin
    if (decode_i.atomic_op) begin
      resp = ld_field; // old value.
    end else if (decode_i.ld_op && decode_i.mask_op) begin
      resp = lm_word;
    end else if (decode_i.ld_op) begin
      resp = ld_field;
    end else begin
      resp = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      v_o <= 1'b0;
    end else begin
      v_o <= v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    data_o <= resp;
  end

endmodule

//--- verilog/dmem_decode.sv
// Stage-1 opcode decoder.
// Turns the request opcode into operation flags and registers them together
// with the valid bit and the request fields for the stage-2 data unit.

`timescale 1ns/1ps
`include "dmem_config.svh"

module dmem_decode
  import dmem_pkg::*;
  (
    input logic clk_i
    , input logic rst_n_i
    , input logic v_i
    , input dmem_opcode_e opcode_i
    , input logic [`DMEM_ADDR_W-1:0] addr_i
    , input logic [`DMEM_DATA_W-1:0] data_i
    , input logic [`DMEM_BYTES-1:0] mask_i
    , output dmem_decode_s decode_o
    , output logic v_o
    , output logic [$clog2(`DMEM_WORDS)-1:0] index_o
    , output logic [$clog2(`DMEM_BYTES)-1:0] offset_o
    , output logic [`DMEM_DATA_W-1:0] data_o
    , output logic [`DMEM_BYTES-1:0] mask_o
  );

  localparam int OFF_W = $clog2(`DMEM_BYTES);

  dmem_decode_s decode_n;

  always_comb begin
    decode_n = '0;
    decode_n.amo_subop = e_dmem_amo_swap;

    case (opcode_i)
      LB, LH, LW, LD: begin
        decode_n.ld_op = 1'b1;
        decode_n.sigext_op = 1'b1;
      end
      LBU, LHU, LWU, LDU: decode_n.ld_op = 1'b1;
      SB, SH, SW, SD: decode_n.st_op = 1'b1;
      LM: begin
        decode_n.ld_op = 1'b1;
        decode_n.mask_op = 1'b1;
      end
      SM: begin
        decode_n.st_op = 1'b1;
        decode_n.mask_op = 1'b1;
      end
      default: begin
        // atomics return the old value sign-extended.
        decode_n.atomic_op = opcode_i[5];
        decode_n.sigext_op = opcode_i[5];
        decode_n.amo_subop = dmem_amo_subop_e'(opcode_i[3:0]);
      end
    endcase

    case (opcode_i)
      LD, LDU, SD, AMOSWAP_D, AMOADD_D, AMOXOR_D, AMOAND_D, AMOOR_D,
      AMOMIN_D, AMOMAX_D, AMOMINU_D, AMOMAXU_D, LM, SM: decode_n.data_size = e_dmem_size_double;
      LW, LWU, SW, AMOSWAP_W, AMOADD_W, AMOXOR_W, AMOAND_W, AMOOR_W,
      AMOMIN_W, AMOMAX_W, AMOMINU_W, AMOMAXU_W: decode_n.data_size = e_dmem_size_word;
      LH, LHU, SH: decode_n.data_size = e_dmem_size_half;
      default: decode_n.data_size = e_dmem_size_byte;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      v_o <= 1'b0;
    end else begin
      v_o <= v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    decode_o <= decode_n;
    index_o <= addr_i[`DMEM_ADDR_W-1:OFF_W];
    offset_o <= addr_i[OFF_W-1:0];
    data_o <= data_i;
    mask_o <= mask_i;
  end

endmodule

//--- verilog/dmem_pkg.sv
// Shared types of the data-memory subsystem: opcodes, atomic sub-ops,
// access sizes and the decoded operation struct.
// Imported by the decoder, the data unit and the top level.

package dmem_pkg;

  typedef enum logic [5:0] {
    LB        = 6'b000000
    , LH      = 6'b000001
    , LW      = 6'b000010
    , LD      = 6'b000011
    , LBU     = 6'b000100
    , LHU     = 6'b000101
    , LWU     = 6'b000110
    , LDU     = 6'b000111
    , SB      = 6'b001000
    , SH      = 6'b001001
    , SW      = 6'b001010
    , SD      = 6'b001011
    , LM      = 6'b001100
    , SM      = 6'b001101
    , AMOSWAP_W = 6'b100000
    , AMOADD_W  = 6'b100001
    , AMOXOR_W  = 6'b100010
    , AMOAND_W  = 6'b100011
    , AMOOR_W   = 6'b100100
    , AMOMIN_W  = 6'b100101
    , AMOMAX_W  = 6'b100110
    , AMOMINU_W = 6'b100111
    , AMOMAXU_W = 6'b101000
    , AMOSWAP_D = 6'b110000
    , AMOADD_D  = 6'b110001
    , AMOXOR_D  = 6'b110010
    , AMOAND_D  = 6'b110011
    , AMOOR_D   = 6'b110100
    , AMOMIN_D  = 6'b110101
    , AMOMAX_D  = 6'b110110
    , AMOMINU_D = 6'b110111
    , AMOMAXU_D = 6'b111000
  } dmem_opcode_e;

  // sub-op codes track the low 4 opcode bits of the atomics.
  typedef enum logic [3:0] {
    e_dmem_amo_swap   = 4'b0000
    , e_dmem_amo_add  = 4'b0001
    , e_dmem_amo_xor  = 4'b0010
    , e_dmem_amo_and  = 4'b0011
    , e_dmem_amo_or   = 4'b0100
    , e_dmem_amo_min  = 4'b0101
    , e_dmem_amo_max  = 4'b0110
    , e_dmem_amo_minu = 4'b0111
    , e_dmem_amo_maxu = 4'b1000
  } dmem_amo_subop_e;

  typedef enum logic [1:0] {
    e_dmem_size_byte     = 2'b00
    , e_dmem_size_half   = 2'b01
    , e_dmem_size_word   = 2'b10
    , e_dmem_size_double = 2'b11
  } dmem_size_e;

  typedef struct packed {
    dmem_size_e data_size;
    logic ld_op;
    logic st_op;
    logic mask_op;
    logic sigext_op;
    logic atomic_op;
    dmem_amo_subop_e amo_subop;
  } dmem_decode_s;

endpackage

//--- verilog/dmem_top.sv
// Top level of the data-memory subsystem.
// One request per cycle, answered two cycles later in request order.
// The decoder and the array form stage 1, the data unit forms stage 2.

`timescale 1ns/1ps
`include "dmem_config.svh"

module dmem_top
  import dmem_pkg::*;
  (
    input logic clk_i
    , input logic rst_n_i
    , input logic v_i
    , input dmem_opcode_e opcode_i
    , input logic [`DMEM_ADDR_W-1:0] addr_i
    , input logic [`DMEM_DATA_W-1:0] data_i
    , input logic [`DMEM_BYTES-1:0] mask_i
    , output logic v_o
    , output logic [`DMEM_DATA_W-1:0] data_o
  );

  localparam int OFF_W = $clog2(`DMEM_BYTES);

  dmem_decode_s s1_decode;
  logic s1_v; // stage-2 valid.
  logic [$clog2(`DMEM_WORDS)-1:0] s1_index;
  logic [OFF_W-1:0] s1_offset;
  logic [`DMEM_DATA_W-1:0] s1_data;
  logic [`DMEM_BYTES-1:0] s1_mask;
  logic [`DMEM_DATA_W-1:0] rd_data;

  dmem_wr_if wr_if ();

  dmem_decode decode (
    .clk_i(clk_i)
    , .rst_n_i(rst_n_i)
    , .v_i(v_i)
    , .opcode_i(opcode_i)
    , .addr_i(addr_i)
    , .data_i(data_i)
    , .mask_i(mask_i)
    , .decode_o(s1_decode)
    , .v_o(s1_v)
    , .index_o(s1_index)
    , .offset_o(s1_offset)
    , .data_o(s1_data)
    , .mask_o(s1_mask)
  );

  dmem_array array (
    .clk_i(clk_i)
    , .rd_index_i(addr_i[`DMEM_ADDR_W-1:OFF_W])
    , .rd_data_o(rd_data)
    , .wr(wr_if.array)
  );

  dmem_data_unit data_unit (
    .clk_i(clk_i)
    , .rst_n_i(rst_n_i)
    , .v_i(s1_v)
    , .decode_i(s1_decode)
    , .index_i(s1_index)
    , .offset_i(s1_offset)
    , .data_i(s1_data)
    , .mask_i(s1_mask)
    , .rd_data_i(rd_data)
    , .wr(wr_if.unit)
    , .v_o(v_o)
    , .data_o(data_o)
  );

endmodule

//--- verilog/dmem_wr_if.sv
// Write port from the stage-2 data unit into the data array.
// The unit drives a byte-masked word write; the array applies it on the next edge.

`timescale 1ns/1ps
`include "dmem_config.svh"

interface dmem_wr_if;

  logic wr_v;
  logic [$clog2(`DMEM_WORDS)-1:0] wr_index;
  logic [`DMEM_DATA_W-1:0] wr_data; // bytes already placed in their lanes.
  logic [`DMEM_BYTES-1:0] wr_mask;

  modport unit (output wr_v, output wr_index, output wr_data, output wr_mask);

  modport array (input wr_v, input wr_index, input wr_data, input wr_mask);

endinterface
